//--- verilog/panel_pkg.sv
// Function-key codes and line counts for the control panel, imported by the panel modules

package panel_pkg;

	// Code carried on the fn port of the I/O bus
	typedef logic [3:0] fn_code_t;

	// Level switches
	localparam fn_code_t FN_START = 4'd0;
	localparam fn_code_t FN_MODE = 4'd1;
	localparam fn_code_t FN_CLOCK = 4'd2;
	localparam fn_code_t FN_STOPN = 4'd3;

	// Momentary keys, cleared by the panel one cycle after being set
	localparam fn_code_t FN_STEP = 4'd4;
	localparam fn_code_t FN_FETCH = 4'd5;
	localparam fn_code_t FN_STORE = 4'd6;
	localparam fn_code_t FN_CYCLE = 4'd7;
	localparam fn_code_t FN_LOAD = 4'd8;
	localparam fn_code_t FN_BIN = 4'd9;
	localparam fn_code_t FN_OPRQ = 4'd10;
	localparam fn_code_t FN_CLEAR = 4'd11;

	// Width of the latched function-key vector
	localparam int FN_COUNT = 12;

	// Rotary register-select lines: wre rsc rsb rsa wic wac war wir wrs wrz wkb
	localparam int ROT_LINES = 11;

	// Lamps shown on the display
	localparam int IND_LINES = 10;

endpackage

//--- verilog/panel_input.sv
// Latches data keys, rotary position and function keys from the I/O bus strobes; decodes rotary

`timescale 1ns/1ps

module panel_input (
	input  logic                            clk_sys,
	input  logic                            hlt_n,
	input  logic [0:15]                     keys,
	input  logic                            keys_trig,
	input  logic [0:3]                      rotary_in,
	input  logic                            rotary_trig,
	input  panel_pkg::fn_code_t             fn,
	input  logic                            fn_v,
	input  logic                            fn_trig,
	output logic [0:15]                     kl,
	output logic [0:3]                      rotary_pos,
	output logic [panel_pkg::FN_COUNT-1:0]  fnkey,
	output logic [panel_pkg::ROT_LINES-1:0] rot_sel
);

	import panel_pkg::*;

	// Bits that hold their value between strobes
	localparam logic [FN_COUNT-1:0] LEVEL_MASK = FN_COUNT'((1 << FN_START) | (1 << FN_MODE) |
		(1 << FN_CLOCK) | (1 << FN_STOPN));

	logic [FN_COUNT-1:0] fnkey_next;

	// Data keys
	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			kl <= '0;
		end else if (keys_trig) begin
			kl <= keys;
		end
	end

	// Rotary selector position
	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			rotary_pos <= '0;
		end else if (rotary_trig) begin
			rotary_pos <= rotary_in;
		end
	end

	// Momentary bits drop back to zero unless written this cycle
	always_comb begin
		fnkey_next = fnkey & LEVEL_MASK;
		if (fn_trig && (int'(fn) < FN_COUNT)) begin
			fnkey_next[fn] = fn_v;
		end
	end

	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			fnkey <= '0;
		end else begin
			fnkey <= fnkey_next;
		end
	end

	// Positions 11 to 15 select no register
	always_comb begin
		rot_sel = '0;
		if (int'(rotary_pos) < ROT_LINES) begin
			rot_sel[rotary_pos] = 1'b1;
		end
	end

	a_rot_sel_onehot: assert property (
		@(posedge clk_sys) disable iff (hlt_n)
		$onehot0(rot_sel)
	) else $error("rot_sel has more than one line active: %b", rot_sel);

endmodule

//--- verilog/panel_switch_fsm.sv
// Derives run switch edges, stop_n toggle and p0-gated momentary commands from the function keys

`timescale 1ns/1ps

module panel_switch_fsm (
	input  logic                           clk_sys,
	input  logic                           hlt_n,
	input  logic                           p0,
	input  logic [panel_pkg::FN_COUNT-1:0] fnkey,
	output logic                           work,
	output logic                           start,
	output logic                           stop,
	output logic                           mode,
	output logic                           stop_n,
	output logic                           dcl,
	output logic                           step,
	output logic                           fetch,
	output logic                           store,
	output logic                           cycle,
	output logic                           load,
	output logic                           bin,
	output logic                           oprq,
	output logic                           clock_en
);

	import panel_pkg::*;

	// Switch levels seen in the previous cycle
	logic work_q;
	logic stopn_key_q;

	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			work_q <= 1'b0;
			stopn_key_q <= 1'b0;
		end else begin
			work_q <= fnkey[FN_START];
			stopn_key_q <= fnkey[FN_STOPN];
		end
	end

	// Each press of the stop_n switch flips the line
	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			stop_n <= 1'b0;
		end else if (fnkey[FN_STOPN] && !stopn_key_q) begin
			stop_n <= ~stop_n;
		end
	end

	// Run switch and its edges
	assign work = fnkey[FN_START];
	assign start = work & ~work_q;
	assign stop = ~work & work_q;

	assign mode = fnkey[FN_MODE];
	assign clock_en = fnkey[FN_CLOCK];

	assign dcl = fnkey[FN_CLEAR];
	assign step = fnkey[FN_STEP];
	assign oprq = fnkey[FN_OPRQ];

	// Memory and loading commands only act with the CPU in p0
	assign fetch = fnkey[FN_FETCH] & p0;
	assign store = fnkey[FN_STORE] & p0;
	assign cycle = fnkey[FN_CYCLE] & p0;
	assign load = fnkey[FN_LOAD] & p0;
	assign bin = fnkey[FN_BIN] & p0;

	// stop_n only flips the cycle after the switch goes from off to on
	a_stop_n_toggle: assert property (
		@(posedge clk_sys) disable iff (hlt_n)
		$changed(stop_n) |-> $past(fnkey[FN_STOPN]) && !$past(fnkey[FN_STOPN], 2)
	) else $error("stop_n changed without a rising stop_n switch");

	a_start_then_work: assert property (
		@(posedge clk_sys) disable iff (hlt_n)
		start |=> work
	) else $error("work dropped one cycle after start");

endmodule

//--- verilog/panel_timer.sv
// Real-time clock: single-cycle zegar pulse once per timer period while enabled

`timescale 1ns/1ps

module panel_timer #(
	parameter int CLK_SYS_HZ = 50_000_000,
	parameter int TIMER_CYCLE_MS = 10
) (
	input  logic clk_sys,
	input  logic hlt_n,
	input  logic enable,
	output logic zegar
);

	// Clock cycles per real-time clock tick
	localparam int PERIOD = CLK_SYS_HZ * TIMER_CYCLE_MS / 1000;
	localparam int CNT_W = $clog2(PERIOD + 1);

	logic [CNT_W-1:0] cnt;

	// Held at a full period while disabled, so the first tick comes a whole period in
	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			cnt <= CNT_W'(PERIOD);
		end else if (!enable) begin
			cnt <= CNT_W'(PERIOD);
		end else if (cnt == '0) begin
			cnt <= CNT_W'(PERIOD - 1);
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign zegar = enable && (cnt == '0);

	// No pulse in the first cycle after the clock switch turns on
	a_zegar_after_enable: assert property (
		@(posedge clk_sys) disable iff (hlt_n)
		zegar |-> $past(enable)
	) else $error("zegar pulse in the first cycle of the clock switch");

endmodule

//--- verilog/display_scan.sv
// Multiplexed 8-digit 7-segment display of the w bus, rotary position and indicator lamps

`timescale 1ns/1ps

module display_scan #(
	parameter int CLK_SYS_HZ = 50_000_000,
	parameter int SCAN_HZ = 1000
) (
	input  logic                            clk_sys,
	input  logic                            hlt_n,
	input  logic [0:15]                     w,
	input  logic [panel_pkg::ROT_LINES-1:0] rot_sel,
	input  logic [panel_pkg::IND_LINES-1:0] indicators,
	output logic [7:0]                      SEG,
	output logic [7:0]                      DIG
);

	import panel_pkg::*;

	// Cycles each digit stays lit
	localparam int DIGIT_CYCLES = CLK_SYS_HZ / (SCAN_HZ * 8);
	localparam int PRESC_W = $clog2(DIGIT_CYCLES + 1);

	logic [PRESC_W-1:0] presc;
	logic [2:0]         dig_idx;
	logic               scan_on;
	logic               rot_found;
	logic [3:0]         rot_idx;
	logic [7:0]         seg_on;

	// Segments a to g in bits 0 to 6, active high
	function automatic logic [6:0] hex_seg(input logic [3:0] v);
		case (v)
			4'h0: hex_seg = 7'h3f;
			4'h1: hex_seg = 7'h06;
			4'h2: hex_seg = 7'h5b;
			4'h3: hex_seg = 7'h4f;
			4'h4: hex_seg = 7'h66;
			4'h5: hex_seg = 7'h6d;
			4'h6: hex_seg = 7'h7d;
			4'h7: hex_seg = 7'h07;
			4'h8: hex_seg = 7'h7f;
			4'h9: hex_seg = 7'h6f;
			4'ha: hex_seg = 7'h77;
			4'hb: hex_seg = 7'h7c;
			4'hc: hex_seg = 7'h39;
			4'hd: hex_seg = 7'h5e;
			4'he: hex_seg = 7'h79;
			default: hex_seg = 7'h71;
		endcase
	endfunction

	// Prescaler and digit counter, display stays dark until the first step
	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			presc <= '0;
			dig_idx <= '0;
			scan_on <= 1'b0;
		end else if (presc == PRESC_W'(DIGIT_CYCLES - 1)) begin
			presc <= '0;
			if (scan_on) begin
				dig_idx <= dig_idx + 1'b1;
			end
			scan_on <= 1'b1;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	// Which register the rotary selects
	always_comb begin
		rot_found = 1'b0;
		rot_idx = '0;
		for (int i = 0; i < ROT_LINES; i++) begin
			if (rot_sel[i]) begin
				rot_found = 1'b1;
				rot_idx = 4'(i);
			end
		end
	end

	always_comb begin
		seg_on = '0;
		case (dig_idx)
			3'd0, 3'd1, 3'd2, 3'd3: seg_on = {1'b0, hex_seg(w[4 * dig_idx[1:0] +: 4])};
			3'd4: seg_on = rot_found ? {1'b0, hex_seg(rot_idx)} : 8'h00;
			3'd5: seg_on = indicators[IND_LINES-1:2];
			3'd6: seg_on = {6'b0, indicators[1:0]};
			default: seg_on = 8'h00;
		endcase
	end

	// Both segments and digit enables are active low
	assign SEG = scan_on ? ~seg_on : 8'hff;
	assign DIG = scan_on ? ~(8'b1 << dig_idx) : 8'hff;

	a_single_digit: assert property (
		@(posedge clk_sys) disable iff (hlt_n)
		$onehot0(~DIG)
	) else $error("more than one digit enabled: %b", DIG);

endmodule

//--- verilog/cpu_panel.sv
// Operator control panel top level, sits between the I/O bus host and the CPU

`timescale 1ns/1ps

module cpu_panel #(
	parameter int CLK_SYS_HZ = 50_000_000,
	parameter int TIMER_CYCLE_MS = 10,
	parameter int SCAN_HZ = 1000
) (
	input  logic                            clk_sys,
	input  logic                            hlt_n,
	// I/O bus events
	input  logic [0:15]                     keys,
	input  logic                            keys_trig,
	input  logic [0:3]                      rotary_in,
	input  logic                            rotary_trig,
	input  panel_pkg::fn_code_t             fn,
	input  logic                            fn_v,
	input  logic                            fn_trig,
	// CPU state
	input  logic [0:15]                     w,
	input  logic                            p,
	input  logic                            p0,
	input  logic                            mc_0,
	input  logic                            alarm,
	input  logic                            _wait,
	input  logic                            irq,
	input  logic                            q,
	input  logic                            run,
	// CPU controls
	output logic [0:15]                     kl,
	output logic                            work,
	output logic                            start,
	output logic                            stop,
	output logic                            mode,
	output logic                            stop_n,
	output logic                            dcl,
	output logic                            step,
	output logic                            fetch,
	output logic                            store,
	output logic                            cycle,
	output logic                            load,
	output logic                            bin,
	output logic                            oprq,
	output logic                            zegar,
	output logic                            wre,
	output logic                            rsc,
	output logic                            rsb,
	output logic                            rsa,
	output logic                            wic,
	output logic                            wac,
	output logic                            war,
	output logic                            wir,
	output logic                            wrs,
	output logic                            wrz,
	output logic                            wkb,
	// Back to the I/O bus and the display
	output logic [0:3]                      rotary_pos,
	output logic [panel_pkg::IND_LINES-1:0] indicators,
	output logic [7:0]                      SEG,
	output logic [7:0]                      DIG
);

	import panel_pkg::*;

	logic [FN_COUNT-1:0]  fnkey;
	logic [ROT_LINES-1:0] rot_sel;
	logic                 clock_en;

	assign {wre, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb} = rot_sel;

	// Lamp order as wired on the panel
	assign indicators = {mode, stop_n, clock_en, q, p, ~mc_0, irq, run, _wait, alarm};

	panel_input u_input (
		.clk_sys(clk_sys), .hlt_n(hlt_n),
		.keys(keys), .keys_trig(keys_trig),
		.rotary_in(rotary_in), .rotary_trig(rotary_trig),
		.fn(fn), .fn_v(fn_v), .fn_trig(fn_trig),
		.kl(kl), .rotary_pos(rotary_pos), .fnkey(fnkey), .rot_sel(rot_sel)
	);

	panel_switch_fsm u_switch (
		.clk_sys(clk_sys), .hlt_n(hlt_n), .p0(p0), .fnkey(fnkey),
		.work(work), .start(start), .stop(stop), .mode(mode), .stop_n(stop_n),
		.dcl(dcl), .step(step), .fetch(fetch), .store(store), .cycle(cycle),
		.load(load), .bin(bin), .oprq(oprq), .clock_en(clock_en)
	);

	panel_timer #(
		.CLK_SYS_HZ(CLK_SYS_HZ),
		.TIMER_CYCLE_MS(TIMER_CYCLE_MS)
	) u_timer (
		.clk_sys(clk_sys), .hlt_n(hlt_n), .enable(clock_en), .zegar(zegar)
	);

	display_scan #(
		.CLK_SYS_HZ(CLK_SYS_HZ),
		.SCAN_HZ(SCAN_HZ)
	) u_display (
		.clk_sys(clk_sys), .hlt_n(hlt_n),
		.w(w), .rot_sel(rot_sel), .indicators(indicators),
		.SEG(SEG), .DIG(DIG)
	);

endmodule

//--- test/tb_cpu_panel.sv
// Self-checking testbench for the control panel, run as the simulation top with the panel sources

`timescale 1ns/1ps

module tb_cpu_panel;

	import panel_pkg::*;

	localparam int CLK_SYS_HZ = 1000;
	localparam int TIMER_CYCLE_MS = 10;
	localparam int SCAN_HZ = 25;
	localparam int TICK = CLK_SYS_HZ * TIMER_CYCLE_MS / 1000;
	localparam int DIGIT_CYCLES = CLK_SYS_HZ / (SCAN_HZ * 8);

	// Standard gfedcba patterns for 0 to F
	localparam logic [6:0] HEX_SEG [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
		7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic clk_sys, hlt_n;
	logic [0:15] keys, w, kl;
	logic keys_trig, rotary_trig, fn_v, fn_trig;
	logic [0:3] rotary_in, rotary_pos;
	fn_code_t fn;
	logic p, p0, mc_0, alarm, _wait, irq, q, run;
	logic work, start, stop, mode, stop_n, dcl, step, fetch, store, cycle, load, bin, oprq, zegar;
	logic wre, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb;
	logic [IND_LINES-1:0] indicators;
	logic [7:0] SEG, DIG;

	// Reference state rebuilt from the bus events
	logic [15:0] exp_kl;
	logic [3:0] exp_rot;
	logic exp_work, exp_work_q, exp_mode, exp_clk, exp_stopn_lvl, toggle_due, exp_stop_n;
	logic [FN_COUNT-1:0] exp_pulse;
	int en_cycles;
	int scan_cycles;
	logic [31:0] rng_state;
	logic [10:0] rot_lines;
	logic [7:0] mom_out;
	logic [9:0] exp_ind;
	logic exp_zegar;
	logic [7:0] exp_dig;

	assign rot_lines = {wre, rsc, rsb, rsa, wic, wac, war, wir, wrs, wrz, wkb};
	assign mom_out = {dcl, oprq, bin, load, cycle, store, fetch, step};
	assign exp_ind = {exp_mode, exp_stop_n, exp_clk, q, p, ~mc_0, irq, run, _wait, alarm};
	assign exp_zegar = exp_clk && (en_cycles != 0) && (en_cycles % TICK == 0);

	// Display dark for one digit time after reset, then digits 0 to 7 in turn
	assign exp_dig = (scan_cycles < DIGIT_CYCLES) ? 8'hff :
		~(8'b1 << ((scan_cycles / DIGIT_CYCLES - 1) % 8));

	cpu_panel #(
		.CLK_SYS_HZ(CLK_SYS_HZ),
		.TIMER_CYCLE_MS(TIMER_CYCLE_MS),
		.SCAN_HZ(SCAN_HZ)
	) u_dut (.*);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (hlt_n) begin
			exp_kl <= '0;
			exp_rot <= '0;
			{exp_work, exp_work_q, exp_mode, exp_clk} <= '0;
			{exp_stopn_lvl, toggle_due, exp_stop_n} <= '0;
			exp_pulse <= '0;
			en_cycles <= 0;
			scan_cycles <= 0;
		end else begin
			if (keys_trig) begin
				exp_kl <= keys;
			end
			if (rotary_trig) begin
				exp_rot <= rotary_in;
			end
			exp_work_q <= exp_work;
			exp_pulse <= '0;
			// stop_n flips one cycle after the switch level rises
			toggle_due <= fn_trig && (fn == FN_STOPN) && fn_v && !exp_stopn_lvl;
			if (toggle_due) begin
				exp_stop_n <= ~exp_stop_n;
			end
			en_cycles <= exp_clk ? en_cycles + 1 : 0;
			scan_cycles <= scan_cycles + 1;
			if (fn_trig) begin
				case (fn)
					FN_START: exp_work <= fn_v;
					FN_MODE: exp_mode <= fn_v;
					FN_CLOCK: exp_clk <= fn_v;
					FN_STOPN: exp_stopn_lvl <= fn_v;
					default: if (fn <= FN_CLEAR) exp_pulse[fn] <= fn_v;
				endcase
			end
		end
	end

	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[30:15];
	endfunction

	function automatic logic [10:0] line_expect(input logic [3:0] pos);
		return (pos < 4'd11) ? (11'b1 << pos) : 11'b0;
	endfunction

	// Memory and loading commands need p0 in the output cycle
	function automatic logic [7:0] mom_expect(input logic [11:0] pulse, input logic p0v);
		return {pulse[FN_CLEAR], pulse[FN_OPRQ], pulse[FN_BIN] & p0v, pulse[FN_LOAD] & p0v,
			pulse[FN_CYCLE] & p0v, pulse[FN_STORE] & p0v, pulse[FN_FETCH] & p0v, pulse[FN_STEP]};
	endfunction

	function automatic logic [7:0] seg_expect(input logic [7:0] dig, input logic [15:0] wv,
		input logic [3:0] pos, input logic [9:0] ind);
		logic [7:0] lit;
		int k;
		k = 0;
		for (int i = 0; i < 8; i++) begin
			if (!dig[i]) begin
				k = i;
			end
		end
		case (k)
			0, 1, 2, 3: lit = {1'b0, HEX_SEG[wv[15 - 4 * k -: 4]]};
			4: lit = (pos < 4'd11) ? {1'b0, HEX_SEG[pos]} : 8'h00;
			5: lit = ind[9:2];
			6: lit = {6'b0, ind[1:0]};
			default: lit = 8'h00;
		endcase
		return ~lit;
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] expv,
		input logic [15:0] actv);
		$display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
		$display("Test failures found");
		$fatal(1, "stopped on first mismatch");
	endtask

	task automatic timeout_abort(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("Test failures found");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic send_keys(input logic [15:0] v);
		@(posedge clk_sys);
		keys <= v;
		keys_trig <= 1'b1;
		@(posedge clk_sys);
		keys_trig <= 1'b0;
		keys <= ~v;
	endtask

	task automatic send_rotary(input logic [3:0] v);
		@(posedge clk_sys);
		rotary_in <= v;
		rotary_trig <= 1'b1;
		@(posedge clk_sys);
		rotary_trig <= 1'b0;
		rotary_in <= ~v;
	endtask

	task automatic send_fn(input fn_code_t code, input logic v);
		@(posedge clk_sys);
		fn <= code;
		fn_v <= v;
		fn_trig <= 1'b1;
		@(posedge clk_sys);
		fn_trig <= 1'b0;
	endtask

	// p0 flips between the strobe cycle and the output cycle
	task automatic press_momentary(input fn_code_t code, input logic p0v);
		@(posedge clk_sys);
		fn <= code;
		fn_v <= 1'b1;
		fn_trig <= 1'b1;
		p0 <= ~p0v;
		@(posedge clk_sys);
		fn_trig <= 1'b0;
		p0 <= p0v;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		hlt_n <= 1'b1;
		repeat (3) @(posedge clk_sys);
		hlt_n <= 1'b0;
	endtask

	task automatic wait_for_zegar(input int limit);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(negedge clk_sys);
			seen = zegar;
			n++;
		end
		if (!seen) begin
			timeout_abort("a zegar pulse");
		end
	endtask

	task automatic wait_for_digit(input int k, input int limit);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(negedge clk_sys);
			seen = !DIG[k];
			n++;
		end
		if (!seen) begin
			timeout_abort($sformatf("display digit %0d", k));
		end
	endtask

	a_kl: assert property (@(posedge clk_sys) disable iff (hlt_n) kl == exp_kl)
		else report_mismatch("kl", $sampled(exp_kl), $sampled(kl));
	a_rot: assert property (@(posedge clk_sys) disable iff (hlt_n) rotary_pos == exp_rot)
		else report_mismatch("rotary_pos", $sampled(exp_rot), $sampled(rotary_pos));
	a_lines: assert property (@(posedge clk_sys) disable iff (hlt_n)
		rot_lines == line_expect(exp_rot))
		else report_mismatch("rotary lines", line_expect($sampled(exp_rot)), $sampled(rot_lines));
	a_work: assert property (@(posedge clk_sys) disable iff (hlt_n) work == exp_work)
		else report_mismatch("work", $sampled(exp_work), $sampled(work));
	a_start: assert property (@(posedge clk_sys) disable iff (hlt_n)
		start == (exp_work && !exp_work_q))
		else report_mismatch("start", $sampled(exp_work && !exp_work_q), $sampled(start));
	a_stop: assert property (@(posedge clk_sys) disable iff (hlt_n)
		stop == (!exp_work && exp_work_q))
		else report_mismatch("stop", $sampled(!exp_work && exp_work_q), $sampled(stop));
	a_mode: assert property (@(posedge clk_sys) disable iff (hlt_n) mode == exp_mode)
		else report_mismatch("mode", $sampled(exp_mode), $sampled(mode));
	a_stop_n: assert property (@(posedge clk_sys) disable iff (hlt_n) stop_n == exp_stop_n)
		else report_mismatch("stop_n", $sampled(exp_stop_n), $sampled(stop_n));
	a_mom: assert property (@(posedge clk_sys) disable iff (hlt_n)
		mom_out == mom_expect(exp_pulse, p0))
		else report_mismatch("commands", mom_expect($sampled(exp_pulse), $sampled(p0)),
			$sampled(mom_out));
	a_zegar: assert property (@(posedge clk_sys) disable iff (hlt_n) zegar == exp_zegar)
		else report_mismatch("zegar", $sampled(exp_zegar), $sampled(zegar));
	a_ind: assert property (@(posedge clk_sys) disable iff (hlt_n) indicators == exp_ind)
		else report_mismatch("indicators", $sampled(exp_ind), $sampled(indicators));
	a_dig: assert property (@(posedge clk_sys) disable iff (hlt_n) DIG == exp_dig)
		else report_mismatch("DIG", $sampled(exp_dig), $sampled(DIG));
	a_seg: assert property (@(posedge clk_sys) disable iff (hlt_n)
		DIG != 8'hff |-> SEG == seg_expect(DIG, w, exp_rot, exp_ind))
		else report_mismatch("SEG", seg_expect($sampled(DIG), $sampled(w), $sampled(exp_rot),
			$sampled(exp_ind)), $sampled(SEG));

	initial begin
		logic [15:0] r;
		clk_sys = 1'b0;
		hlt_n = 1'b1;
		rng_state = 32'd4815;
		keys = '0;
		keys_trig = 1'b0;
		rotary_in = '0;
		rotary_trig = 1'b0;
		fn = FN_START;
		fn_v = 1'b0;
		fn_trig = 1'b0;
		w = '0;
		{p, p0, mc_0, alarm, _wait, irq, q, run} = '0;
		repeat (3) @(posedge clk_sys);
		hlt_n <= 1'b0;

		// Key latch, then every rotary position
		for (int i = 0; i < 12; i++) begin
			send_keys(next_rand());
		end
		for (int i = 0; i < 16; i++) begin
			send_rotary(4'(i));
		end

		send_fn(FN_START, 1'b1);
		repeat (4) @(posedge clk_sys);
		send_fn(FN_START, 1'b0);

		// Two full presses, a third left high, then reset clears stop_n
		repeat (2) begin
			send_fn(FN_STOPN, 1'b1);
			send_fn(FN_STOPN, 1'b0);
		end
		send_fn(FN_STOPN, 1'b1);
		apply_reset();

		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			press_momentary(fn_code_t'(FN_STEP + r[2:0]), r[8]);
		end

		send_fn(FN_CLOCK, 1'b1);
		repeat (3) wait_for_zegar(TICK + 2);
		send_fn(FN_CLOCK, 1'b0);
		repeat (3 * TICK) @(posedge clk_sys);

		// Display rounds with lamps lit, one with a blank rotary digit
		send_fn(FN_MODE, 1'b1);
		send_fn(FN_CLOCK, 1'b1);
		for (int round = 0; round < 4; round++) begin
			r = next_rand();
			@(posedge clk_sys);
			w <= next_rand();
			{p, mc_0, alarm, _wait, irq, q, run} <= r[6:0];
			send_rotary((round == 1) ? 4'd13 : r[15:12]);
			for (int k = 0; k < 8; k++) begin
				wait_for_digit(k, 9 * DIGIT_CYCLES);
			end
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

//--- cpu_panel.f
verilog/panel_pkg.sv
verilog/panel_input.sv
verilog/panel_switch_fsm.sv
verilog/panel_timer.sv
verilog/display_scan.sv
verilog/cpu_panel.sv
test/tb_cpu_panel.sv

//--- Bender.yml
package:
  name: cpu_panel

sources:
  - verilog/panel_pkg.sv
  - verilog/panel_input.sv
  - verilog/panel_switch_fsm.sv
  - verilog/panel_timer.sv
  - verilog/display_scan.sv
  - verilog/cpu_panel.sv
  - target: test
    files:
      - test/tb_cpu_panel.sv
